// ==== ctx_pkg.sv ====
package ctx_pkg;

    // context tags are one-hot, one bit per speculative path
    localparam int NUM_CTX = 8;
    localparam int CTX_ID_W = 3;

    localparam int WORD_W = 32;

    // context 0 starts fetching here
    localparam logic [WORD_W-1:0] RESET_PC = '0;

    typedef logic [NUM_CTX-1:0] ctx_t;
    typedef logic [CTX_ID_W-1:0] ctx_id_t;

    // winner of one pc table entry, listed from highest priority down
    typedef enum logic [2:0] {
        src_none,
        src_branch_taken,
        src_branch_fall,
        src_decode,
        src_window,
        src_exec_jump
    } pc_src_e;

    // next-pc report from decoder, window or jump unit
    typedef struct packed {
        logic              valid;
        ctx_t              ctx;
        logic [WORD_W-1:0] next_pc;
    } pc_upd_t;

    // conditional branch seen by the decoder
    typedef struct packed {
        logic              valid;
        ctx_t              ctx;
        logic [WORD_W-1:0] taken_pc;
        logic [WORD_W-1:0] fall_pc;
    } branch_req_t;

    // branch outcome from execute
    typedef struct packed {
        logic hazard;
        ctx_t bad_ctx;
        ctx_t safe_ctx;
        ctx_t resolved_ctx;
    } hazard_t;

    typedef struct packed {
        pc_src_e           src;
        logic [WORD_W-1:0] pc;
    } pc_wr_t;

    typedef struct packed {
        ctx_t              ctx;
        logic [WORD_W-1:0] pc;
        logic [WORD_W-1:0] hint;
    } fetch_req_t;

    // or of the indices of all set bits, exact for a one-hot input
    function automatic ctx_id_t ctx_onehot_to_id(ctx_t onehot);
        ctx_id_t id;
        id = '0;
        for (int i = 0; i < NUM_CTX; i++) begin
            if (onehot[i]) begin
                id |= ctx_id_t'(i);
            end
        end
        return id;
    endfunction

endpackage

// ==== ctx_alloc.sv ====
module ctx_alloc import ctx_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  logic branch_valid,
    output ctx_t branch_ctx_t,
    output ctx_t branch_ctx_f
);

    // fall-through tag of the latest branch
    ctx_t last_ctx;

    // rotate left by one for the taken path
    assign branch_ctx_t = {last_ctx[NUM_CTX-2:0], last_ctx[NUM_CTX-1]};

    // rotate left by two for the fall-through path
    assign branch_ctx_f = {last_ctx[NUM_CTX-3:0], last_ctx[NUM_CTX-1:NUM_CTX-2]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_ctx <= ctx_t'(1);
        end else if (branch_valid) begin
            last_ctx <= branch_ctx_f;
        end
    end

    // rotation must never lose or duplicate the token
    a_last_ctx_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot(last_ctx)
    );

endmodule

// ==== ctx_squash.sv ====
module ctx_squash import ctx_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  hazard_t     exec,
    input  branch_req_t branch,
    input  ctx_t        branch_ctx_t,
    input  ctx_t        branch_ctx_f,
    output ctx_t        active_ctx_next,
    output ctx_t        kill_mask,
    output ctx_t        squash_mask
);

    ctx_t active_ctx;
    ctx_t active_after_hazard;

    // ancestry masks, stored and per step
    ctx_t anc_q [NUM_CTX];
    ctx_t anc_masked [NUM_CTX];
    ctx_t anc_kept [NUM_CTX];
    ctx_t anc_d [NUM_CTX];

    ctx_t resolved_mask;
    ctx_t parent_mask;

    // ancestry of the resolved branch, empty when nothing resolves
    always_comb begin
        resolved_mask = '0;
        for (int i = 0; i < NUM_CTX; i++) begin
            if (exec.resolved_ctx[i]) begin
                resolved_mask |= anc_q[i];
            end
        end
    end

    assign squash_mask = anc_q[ctx_onehot_to_id(exec.bad_ctx)];

    // step 1 and 2: drop resolved ancestry, then find what the hazard kills
    always_comb begin
        for (int i = 0; i < NUM_CTX; i++) begin
            anc_masked[i] = anc_q[i] & ~resolved_mask;
            kill_mask[i] = exec.hazard && ((anc_masked[i] & squash_mask) != '0);
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_CTX; i++) begin
            anc_kept[i] = kill_mask[i] ? '0 : anc_masked[i];
        end
    end

    // fall back to the safe path if the running one was discarded
    assign active_after_hazard = ((kill_mask & active_ctx) != '0) ? exec.safe_ctx
                                                                 : active_ctx;

    // step 3: children inherit the parent's surviving ancestry
    assign parent_mask = anc_kept[ctx_onehot_to_id(branch.ctx)];

    always_comb begin
        for (int i = 0; i < NUM_CTX; i++) begin
            if (branch.valid && (branch_ctx_t[i] || branch_ctx_f[i])) begin
                anc_d[i] = (ctx_t'(1) << i) | parent_mask;
            end else begin
                anc_d[i] = anc_kept[i];
            end
        end
    end

    // fetch follows the taken path of a new branch
    assign active_ctx_next = branch.valid ? branch_ctx_t : active_after_hazard;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active_ctx <= ctx_t'(1);
            for (int i = 0; i < NUM_CTX; i++) begin
                anc_q[i] <= (i == 0) ? ctx_t'(1) : '0;
            end
        end else begin
            active_ctx <= active_ctx_next;
            for (int i = 0; i < NUM_CTX; i++) begin
                anc_q[i] <= anc_d[i];
            end
        end
    end

    // execute must always name somewhere to resume
    a_safe_ctx_present: assert property (
        @(posedge clk) disable iff (!arst_n)
        exec.hazard |-> (exec.safe_ctx != '0)
    );

endmodule

// ==== pc_table_arbiter.sv ====
module pc_table_arbiter import ctx_pkg::*; (
    input  branch_req_t          branch,
    input  ctx_t                 branch_ctx_t,
    input  ctx_t                 branch_ctx_f,
    input  pc_upd_t              dec_upd,
    input  pc_upd_t              win_upd,
    input  pc_upd_t              jump_upd,
    input  ctx_t                 kill_mask,
    output pc_wr_t [NUM_CTX-1:0] pc_wr
);

    // per-writer request vectors, one bit per entry
    ctx_t taken_req;
    ctx_t fall_req;
    ctx_t dec_req;
    ctx_t win_req;
    ctx_t jump_req;

    assign taken_req = branch.valid ? branch_ctx_t : '0;
    assign fall_req = branch.valid ? branch_ctx_f : '0;
    assign dec_req = dec_upd.valid ? dec_upd.ctx : '0;
    assign win_req = win_upd.valid ? win_upd.ctx : '0;

    // a jump on a path being discarded goes nowhere
    assign jump_req = jump_upd.valid ? (jump_upd.ctx & ~kill_mask) : '0;

    always_comb begin
        for (int i = 0; i < NUM_CTX; i++) begin
            if (taken_req[i]) begin
                pc_wr[i].src = src_branch_taken;
                pc_wr[i].pc = branch.taken_pc;
            end else if (fall_req[i]) begin
                pc_wr[i].src = src_branch_fall;
                pc_wr[i].pc = branch.fall_pc;
            end else if (dec_req[i]) begin
                pc_wr[i].src = src_decode;
                pc_wr[i].pc = dec_upd.next_pc;
            end else if (win_req[i]) begin
                pc_wr[i].src = src_window;
                pc_wr[i].pc = win_upd.next_pc;
            end else if (jump_req[i]) begin
                pc_wr[i].src = src_exec_jump;
                pc_wr[i].pc = jump_upd.next_pc;
            end else begin
                // no writer, the table keeps its entry
                pc_wr[i].src = src_none;
                pc_wr[i].pc = '0;
            end
        end
    end

endmodule

// ==== ctx_pc_table.sv ====
module ctx_pc_table import ctx_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  pc_wr_t [NUM_CTX-1:0] pc_wr,
    input  ctx_t                 kill_mask,
    input  ctx_t                 active_ctx_next,
    input  logic                 fetch_accepted,
    input  logic [WORD_W-1:0]    lr_hint,
    output logic                 fetch_order,
    output fetch_req_t           fetch
);

    logic [WORD_W-1:0] pc_q [NUM_CTX];
    logic [WORD_W-1:0] pc_d [NUM_CTX];

    // pending fetch flag per context
    ctx_t pending_q;
    ctx_t pending_live;
    ctx_t pending_d;

    ctx_t wr_hit;
    ctx_t accept_mask;
    ctx_id_t active_id;

    always_comb begin
        for (int i = 0; i < NUM_CTX; i++) begin
            wr_hit[i] = (pc_wr[i].src != src_none);
            pc_d[i] = wr_hit[i] ? pc_wr[i].pc : pc_q[i];
        end
    end

    // pending state as fetch sees it before this cycle's accept
    assign pending_live = wr_hit | (pending_q & ~kill_mask);

    // accept drops the shown context and a write re-arms it
    assign accept_mask = fetch_accepted ? active_ctx_next : '0;
    assign pending_d = wr_hit | (pending_live & ~accept_mask);

    assign active_id = ctx_onehot_to_id(active_ctx_next);

    assign fetch_order = pending_live[active_id];
    assign fetch.ctx = active_ctx_next;
    assign fetch.pc = pc_d[active_id];
    assign fetch.hint = lr_hint;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending_q <= ctx_t'(1);
            for (int i = 0; i < NUM_CTX; i++) begin
                pc_q[i] <= RESET_PC;
            end
        end else begin
            pending_q <= pending_d;
            for (int i = 0; i < NUM_CTX; i++) begin
                pc_q[i] <= pc_d[i];
            end
        end
    end

    // active tag comes from the squash logic and must stay a single path
    a_fetch_ctx_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot(fetch.ctx)
    );

endmodule

// ==== context_manager.sv ====
module context_manager import ctx_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,

    // next-pc reports
    input  pc_upd_t           dec_upd,
    input  pc_upd_t           win_upd,
    input  pc_upd_t           jump_upd,

    // decoder branch and execute outcome
    input  branch_req_t       branch,
    input  hazard_t           exec,

    // fetcher
    input  logic              fetch_accepted,
    input  logic [WORD_W-1:0] lr_hint,
    output logic              fetch_order,
    output fetch_req_t        fetch,

    // tags for the next decoded branch
    output ctx_t              branch_ctx_t,
    output ctx_t              branch_ctx_f,

    output logic              squash,
    output ctx_t              squash_mask
);

    ctx_t active_ctx_next;
    ctx_t kill_mask;
    pc_wr_t [NUM_CTX-1:0] pc_wr;

    assign squash = exec.hazard;

    ctx_alloc ctx_alloc_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .branch_valid (branch.valid),
        .branch_ctx_t (branch_ctx_t),
        .branch_ctx_f (branch_ctx_f)
    );

    ctx_squash ctx_squash_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .exec            (exec),
        .branch          (branch),
        .branch_ctx_t    (branch_ctx_t),
        .branch_ctx_f    (branch_ctx_f),
        .active_ctx_next (active_ctx_next),
        .kill_mask       (kill_mask),
        .squash_mask     (squash_mask)
    );

    pc_table_arbiter pc_table_arbiter_i (
        .branch       (branch),
        .branch_ctx_t (branch_ctx_t),
        .branch_ctx_f (branch_ctx_f),
        .dec_upd      (dec_upd),
        .win_upd      (win_upd),
        .jump_upd     (jump_upd),
        .kill_mask    (kill_mask),
        .pc_wr        (pc_wr)
    );

    ctx_pc_table ctx_pc_table_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .pc_wr           (pc_wr),
        .kill_mask       (kill_mask),
        .active_ctx_next (active_ctx_next),
        .fetch_accepted  (fetch_accepted),
        .lr_hint         (lr_hint),
        .fetch_order     (fetch_order),
        .fetch           (fetch)
    );

endmodule

// ==== tb_context_manager.sv ====
module tb_context_manager import ctx_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 3;
    localparam int RANDOM_ROWS = 48;

    // one table row with inputs first and expected values after
    typedef struct packed {
        pc_upd_t           dec;
        pc_upd_t           win;
        pc_upd_t           jump;
        branch_req_t       br;
        hazard_t           ex;
        logic              acc;
        logic              exp_order;
        ctx_t              exp_ctx;
        logic [WORD_W-1:0] exp_pc;
        logic              exp_squash;
        ctx_t              exp_smask;
        ctx_t              exp_tag_t;
        ctx_t              exp_tag_f;
    } row_t;

    localparam pc_upd_t NO_UPD = '0;
    localparam branch_req_t NO_BR = '0;
    localparam hazard_t NO_EX = '0;

    logic              clk;
    logic              arst_n;
    pc_upd_t           dec_upd;
    pc_upd_t           win_upd;
    pc_upd_t           jump_upd;
    branch_req_t       branch;
    hazard_t           exec;
    logic              fetch_accepted;
    logic [WORD_W-1:0] lr_hint;
    logic              fetch_order;
    fetch_req_t        fetch;
    ctx_t              branch_ctx_t;
    ctx_t              branch_ctx_f;
    logic              squash;
    ctx_t              squash_mask;

    row_t        rows [$];
    bit          table_built;
    int          errors;
    int          checks;
    logic [31:0] lfsr;

    // reference model state
    ctx_t              m_active;
    ctx_t              m_last;
    ctx_t              m_anc [NUM_CTX];
    logic [WORD_W-1:0] m_pc [NUM_CTX];
    ctx_t              m_pend;

    context_manager context_manager_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .dec_upd        (dec_upd),
        .win_upd        (win_upd),
        .jump_upd       (jump_upd),
        .branch         (branch),
        .exec           (exec),
        .fetch_accepted (fetch_accepted),
        .lr_hint        (lr_hint),
        .fetch_order    (fetch_order),
        .fetch          (fetch),
        .branch_ctx_t   (branch_ctx_t),
        .branch_ctx_f   (branch_ctx_f),
        .squash         (squash),
        .squash_mask    (squash_mask)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) begin
            s ^= 32'h8020_0003;
        end
        return s;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic ctx_t rotate_tag(ctx_t t, int n);
        logic [2*NUM_CTX-1:0] twice;
        twice = {t, t} >> (NUM_CTX - n);
        return twice[NUM_CTX-1:0];
    endfunction

    function automatic int tag_index(ctx_t t);
        for (int i = 0; i < NUM_CTX; i++) begin
            if (t[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    function automatic pc_upd_t upd(ctx_t c, logic [WORD_W-1:0] pc);
        return '{valid: 1'b1, ctx: c, next_pc: pc};
    endfunction

    function automatic branch_req_t br_req(ctx_t parent, logic [WORD_W-1:0] tpc,
                                           logic [WORD_W-1:0] fpc);
        return '{valid: 1'b1, ctx: parent, taken_pc: tpc, fall_pc: fpc};
    endfunction

    function automatic hazard_t hz(logic h, ctx_t bad, ctx_t safe, ctx_t resolved);
        return '{hazard: h, bad_ctx: bad, safe_ctx: safe, resolved_ctx: resolved};
    endfunction

    task automatic add_row(pc_upd_t dec, pc_upd_t win, pc_upd_t jump, branch_req_t br,
                           hazard_t ex, logic acc);
        row_t r;
        r = '0;
        r.dec = dec;
        r.win = win;
        r.jump = jump;
        r.br = br;
        r.ex = ex;
        r.acc = acc;
        rows.push_back(r);
    endtask

    task automatic build_directed();
        // reset state and then an accept that drains ctx 0
        add_row(NO_UPD, NO_UPD, NO_UPD, NO_BR, NO_EX, 1'b0);
        add_row(NO_UPD, NO_UPD, NO_UPD, NO_BR, NO_EX, 1'b1);
        add_row(NO_UPD, NO_UPD, NO_UPD, NO_BR, NO_EX, 1'b0);
        // decode on the active ctx and then a hold under back-pressure
        add_row(upd(8'h01, 32'h0000_0100), NO_UPD, NO_UPD, NO_BR, NO_EX, 1'b0);
        add_row(NO_UPD, NO_UPD, NO_UPD, NO_BR, NO_EX, 1'b0);
        add_row(NO_UPD, NO_UPD, NO_UPD, NO_BR, NO_EX, 1'b0);
        add_row(NO_UPD, NO_UPD, NO_UPD, NO_BR, NO_EX, 1'b1);
        add_row(NO_UPD, NO_UPD, NO_UPD, NO_BR, NO_EX, 1'b0);
        // two branches take tags 1 and 2 then 3 and 4
        add_row(NO_UPD, NO_UPD, NO_UPD, br_req(8'h01, 32'h200, 32'h204), NO_EX, 1'b0);
        add_row(NO_UPD, NO_UPD, NO_UPD, NO_BR, NO_EX, 1'b1);
        add_row(NO_UPD, NO_UPD, NO_UPD, br_req(8'h02, 32'h300, 32'h304), NO_EX, 1'b0);
        // mispredict on ctx 1 while a jump into doomed ctx 3 goes nowhere
        add_row(NO_UPD, NO_UPD, upd(8'h08, 32'hdead_beef), NO_BR,
                hz(1'b1, 8'h02, 8'h04, 8'h01), 1'b0);
        add_row(NO_UPD, NO_UPD, NO_UPD, NO_BR, NO_EX, 1'b1);
        // competing writers on ctx 2
        add_row(upd(8'h04, 32'h500), upd(8'h04, 32'h600), upd(8'h04, 32'h700),
                NO_BR, NO_EX, 1'b0);
        add_row(NO_UPD, upd(8'h04, 32'h600), upd(8'h04, 32'h700), NO_BR, NO_EX, 1'b0);
        add_row(NO_UPD, NO_UPD, upd(8'h04, 32'h700), NO_BR, NO_EX, 1'b1);
        // branch tags beat decode and window on the same entries
        add_row(upd(8'h20, 32'h999), upd(8'h40, 32'h888), NO_UPD,
                br_req(8'h04, 32'h800, 32'h804), NO_EX, 1'b0);
        add_row(NO_UPD, NO_UPD, NO_UPD, br_req(8'h20, 32'h900, 32'h904), NO_EX, 1'b1);
        // ctx 2 branch resolves and a mispredict on ctx 5 spares ctx 6
        add_row(NO_UPD, NO_UPD, NO_UPD, NO_BR, hz(1'b0, 8'h00, 8'h00, 8'h04), 1'b0);
        add_row(NO_UPD, NO_UPD, NO_UPD, NO_BR, hz(1'b1, 8'h20, 8'h40, 8'h00), 1'b0);
        // killing ctx 6 falls back to ctx 3 with its branch pc and nothing pending
        add_row(NO_UPD, NO_UPD, NO_UPD, NO_BR, hz(1'b1, 8'h40, 8'h08, 8'h00), 1'b0);
        add_row(NO_UPD, NO_UPD, NO_UPD, NO_BR, NO_EX, 1'b0);
    endtask

    task automatic build_random();
        pc_upd_t     dec;
        pc_upd_t     win;
        pc_upd_t     jump;
        branch_req_t br;
        logic        acc;
        for (int n = 0; n < RANDOM_ROWS; n++) begin
            dec.valid = rand_bits(1) != 0;
            dec.ctx = ctx_t'(1) << rand_bits(3);
            dec.next_pc = rand_bits(32);
            win.valid = rand_bits(1) != 0;
            win.ctx = ctx_t'(1) << rand_bits(3);
            win.next_pc = rand_bits(32);
            jump.valid = rand_bits(1) != 0;
            jump.ctx = ctx_t'(1) << rand_bits(3);
            jump.next_pc = rand_bits(32);
            // a branch in roughly one row of four
            br.valid = rand_bits(2) == 0;
            br.ctx = ctx_t'(1) << rand_bits(3);
            br.taken_pc = rand_bits(32);
            br.fall_pc = rand_bits(32);
            acc = rand_bits(1) != 0;
            add_row(dec, win, jump, br, NO_EX, acc);
        end
    endtask

    // one cycle of the reference model that fills in the expected fields
    task automatic predict(inout row_t r);
        ctx_t              resolved_anc;
        ctx_t              bad_anc;
        ctx_t              kill;
        ctx_t              written;
        ctx_t              live;
        ctx_t              next_active;
        ctx_t              tag_t;
        ctx_t              tag_f;
        ctx_t              parent_anc;
        logic [WORD_W-1:0] new_pc [NUM_CTX];
        resolved_anc = '0;
        kill = '0;
        written = '0;
        for (int i = 0; i < NUM_CTX; i++) begin
            if (r.ex.resolved_ctx[i]) begin
                resolved_anc |= m_anc[i];
            end
        end
        bad_anc = m_anc[tag_index(r.ex.bad_ctx)];
        for (int i = 0; i < NUM_CTX; i++) begin
            m_anc[i] &= ~resolved_anc;
            if (r.ex.hazard && ((m_anc[i] & bad_anc) != '0)) begin
                kill[i] = 1'b1;
                m_anc[i] = '0;
            end
        end
        next_active = ((kill & m_active) != '0) ? r.ex.safe_ctx : m_active;
        tag_t = rotate_tag(m_last, 1);
        tag_f = rotate_tag(m_last, 2);
        if (r.br.valid) begin
            parent_anc = m_anc[tag_index(r.br.ctx)];
            m_anc[tag_index(tag_t)] = tag_t | parent_anc;
            m_anc[tag_index(tag_f)] = tag_f | parent_anc;
            next_active = tag_t;
            m_last = tag_f;
        end
        // lowest priority first, so a stronger writer overrides
        for (int i = 0; i < NUM_CTX; i++) begin
            new_pc[i] = m_pc[i];
            if (r.jump.valid && r.jump.ctx[i] && !kill[i]) begin
                written[i] = 1'b1;
                new_pc[i] = r.jump.next_pc;
            end
            if (r.win.valid && r.win.ctx[i]) begin
                written[i] = 1'b1;
                new_pc[i] = r.win.next_pc;
            end
            if (r.dec.valid && r.dec.ctx[i]) begin
                written[i] = 1'b1;
                new_pc[i] = r.dec.next_pc;
            end
            if (r.br.valid && tag_f[i]) begin
                written[i] = 1'b1;
                new_pc[i] = r.br.fall_pc;
            end
            if (r.br.valid && tag_t[i]) begin
                written[i] = 1'b1;
                new_pc[i] = r.br.taken_pc;
            end
        end
        live = written | (m_pend & ~kill);
        r.exp_order = (live & next_active) != '0;
        r.exp_ctx = next_active;
        r.exp_pc = new_pc[tag_index(next_active)];
        r.exp_squash = r.ex.hazard;
        r.exp_smask = bad_anc;
        r.exp_tag_t = tag_t;
        r.exp_tag_f = tag_f;
        m_pend = r.acc ? (written | (live & ~next_active)) : live;
        m_pc = new_pc;
        m_active = next_active;
    endtask

    task automatic reset_model();
        m_active = ctx_t'(1);
        m_last = ctx_t'(1);
        m_pend = ctx_t'(1);
        for (int i = 0; i < NUM_CTX; i++) begin
            m_anc[i] = (i == 0) ? ctx_t'(1) : '0;
            m_pc[i] = RESET_PC;
        end
    endtask

    task automatic drive_row(int idx, row_t r);
        dec_upd = r.dec;
        win_upd = r.win;
        jump_upd = r.jump;
        branch = r.br;
        exec = r.ex;
        fetch_accepted = r.acc;
        lr_hint = 32'h4000_0000 + idx;
    endtask

    task automatic check_row(int idx, row_t r);
        checks++;
        assert (fetch_order === r.exp_order) else begin
            errors++;
            $display("Error at %0t ns: row %0d fetch_order %b, expected %b",
                     $time, idx, fetch_order, r.exp_order);
        end
        assert (fetch.ctx === r.exp_ctx && fetch.pc === r.exp_pc) else begin
            errors++;
            $display("Error at %0t ns: row %0d fetch ctx %h pc %h, expected ctx %h pc %h",
                     $time, idx, fetch.ctx, fetch.pc, r.exp_ctx, r.exp_pc);
        end
        assert (fetch.hint === lr_hint) else begin
            errors++;
            $display("Error at %0t ns: row %0d hint %h, expected %h",
                     $time, idx, fetch.hint, lr_hint);
        end
        assert (squash === r.exp_squash) else begin
            errors++;
            $display("Error at %0t ns: row %0d squash %b, expected %b",
                     $time, idx, squash, r.exp_squash);
        end
        if (r.ex.hazard) begin
            assert (squash_mask === r.exp_smask) else begin
                errors++;
                $display("Error at %0t ns: row %0d squash_mask %h, expected %h",
                         $time, idx, squash_mask, r.exp_smask);
            end
        end
        assert (branch_ctx_t === r.exp_tag_t && branch_ctx_f === r.exp_tag_f) else begin
            errors++;
            $display("Error at %0t ns: row %0d tags %h/%h, expected %h/%h", $time, idx,
                     branch_ctx_t, branch_ctx_f, r.exp_tag_t, r.exp_tag_f);
        end
    endtask

    initial begin
        row_t r;
        arst_n = 1'b0;
        dec_upd = NO_UPD;
        win_upd = NO_UPD;
        jump_upd = NO_UPD;
        branch = NO_BR;
        exec = NO_EX;
        fetch_accepted = 1'b0;
        lr_hint = '0;
        errors = 0;
        checks = 0;
        lfsr = 32'ha288;
        build_directed();
        build_random();
        reset_model();
        foreach (rows[i]) begin
            r = rows[i];
            predict(r);
            rows[i] = r;
        end
        table_built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        foreach (rows[i]) begin
            drive_row(i, rows[i]);
            // halfway between the falling and the rising edge
            #2;
            check_row(i, rows[i]);
            @(negedge clk);
        end
        drive_row(0, '0);
        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // one clock per row plus reset and some slack
    initial begin
        wait (table_built);
        #((rows.size() + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("watchdog expired before all table rows were checked");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
ctx_pkg.sv
ctx_alloc.sv
ctx_squash.sv
pc_table_arbiter.sv
ctx_pc_table.sv
context_manager.sv
tb_context_manager.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_context_manager
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
